/* verilog/fetch_pkg.sv */
package fetch_pkg;

  // --------------------------------------------------------------------------
  // Core widths
  // --------------------------------------------------------------------------

  // Address and data width
  localparam int XLEN = 64;
  // Instruction width, no compressed encodings
  localparam int ILEN = 32;

  // Fetch starts here after reset
  localparam logic [XLEN-1:0] BOOT_PC = 64'h1000;

  // --------------------------------------------------------------------------
  // Instruction buffer
  // --------------------------------------------------------------------------

  // Entries, also the cap on requests in flight
  localparam int BUF_DEPTH = 4;
  localparam int BUF_IDX_W = 2;

  // --------------------------------------------------------------------------
  // Branch target buffer
  // --------------------------------------------------------------------------

  localparam int BTB_ENTRIES = 16;
  // Index from PC[5:2]
  localparam int BTB_IDX_W = 4;
  // Everything above the index
  localparam int BTB_TAG_W = XLEN - BTB_IDX_W - 2;

  // Fetch control states
  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_RUN,
    FETCH_STALL
  } fetch_state_t;

endpackage

/* verilog/pc_gen.sv */
`timescale 1ns/1ps

module pc_gen (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       pc_adv_i,
  input  logic                       comm_except_raised_i,
  input  logic [fetch_pkg::XLEN-1:0] comm_except_pc_i,
  input  logic                       bu_res_valid_i,
  input  logic                       bu_res_mispredict_i,
  input  logic                       bu_res_taken_i,
  input  logic [fetch_pkg::XLEN-1:0] bu_res_pc_i,
  input  logic [fetch_pkg::XLEN-1:0] bu_res_target_i,
  input  logic                       pred_taken_i,
  input  logic [fetch_pkg::XLEN-1:0] pred_target_i,
  output logic [fetch_pkg::XLEN-1:0] pc_o,
  output logic                       pc_valid_o,
  output logic                       redirect_o
);

  import fetch_pkg::*;

  logic [XLEN-1:0] next_pc;
  logic [XLEN-1:0] add_base;
  logic [XLEN-1:0] seq_pc;
  logic            mispredict;

  // Redirect detection
  assign mispredict = bu_res_valid_i & bu_res_mispredict_i;
  assign redirect_o = comm_except_raised_i | mispredict;
  // Current PC is wrong path while redirecting
  assign pc_valid_o = ~redirect_o;

  // Shared incrementer, resolved branch PC on a mispredict
  assign add_base = mispredict ? bu_res_pc_i : pc_o;
  assign seq_pc   = add_base + XLEN'(ILEN / 8);

  // --------------------------------------------------------------------------
  // Next PC priority
  // --------------------------------------------------------------------------
  always_comb begin
    if (comm_except_raised_i) begin
      next_pc = comm_except_pc_i;
    end else if (mispredict) begin
      // Taken goes to target, not taken falls through
      next_pc = bu_res_taken_i ? bu_res_target_i : seq_pc;
    end else if (pred_taken_i) begin
      next_pc = pred_target_i;
    end else begin
      next_pc = seq_pc;
    end
  end

  // PC register, loads only when fetch control advances
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_o <= BOOT_PC;
    end else if (pc_adv_i) begin
      pc_o <= next_pc;
    end
  end

  // Redirect and prediction sources must keep word alignment
  a_pc_aligned: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) pc_o[1:0] == 2'b00
  );

endmodule

/* verilog/branch_predictor.sv */
`timescale 1ns/1ps

module branch_predictor (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic [fetch_pkg::XLEN-1:0] lookup_pc_i,
  input  logic                       upd_valid_i,
  input  logic [fetch_pkg::XLEN-1:0] upd_pc_i,
  input  logic [fetch_pkg::XLEN-1:0] upd_target_i,
  input  logic                       upd_taken_i,
  output logic                       pred_taken_o,
  output logic [fetch_pkg::XLEN-1:0] pred_target_o
);

  import fetch_pkg::*;

  // Entry storage
  logic [BTB_ENTRIES-1:0] valid_q;
  logic [BTB_TAG_W-1:0]   tag_q    [BTB_ENTRIES];
  logic [XLEN-1:0]        target_q [BTB_ENTRIES];
  logic [1:0]             cnt_q    [BTB_ENTRIES];

  logic [BTB_IDX_W-1:0] lkp_idx;
  logic [BTB_TAG_W-1:0] lkp_tag;
  logic [BTB_IDX_W-1:0] upd_idx;
  logic [BTB_TAG_W-1:0] upd_tag;
  logic                 upd_hit;
  logic [1:0]           cnt_new;

  // --------------------------------------------------------------------------
  // Lookup
  // --------------------------------------------------------------------------
  assign lkp_idx = lookup_pc_i[BTB_IDX_W+1:2];
  assign lkp_tag = lookup_pc_i[XLEN-1:BTB_IDX_W+2];

  // Counter MSB set means weakly or strongly taken
  assign pred_taken_o  = valid_q[lkp_idx] && (tag_q[lkp_idx] == lkp_tag) &&
                         cnt_q[lkp_idx][1];
  assign pred_target_o = target_q[lkp_idx];

  // --------------------------------------------------------------------------
  // Training
  // --------------------------------------------------------------------------
  assign upd_idx = upd_pc_i[BTB_IDX_W+1:2];
  assign upd_tag = upd_pc_i[XLEN-1:BTB_IDX_W+2];
  assign upd_hit = valid_q[upd_idx] && (tag_q[upd_idx] == upd_tag);

  // Saturating counter step, fresh entries start weak
  always_comb begin
    if (!upd_hit) begin
      cnt_new = upd_taken_i ? 2'd2 : 2'd1;
    end else if (upd_taken_i && (cnt_q[upd_idx] != 2'd3)) begin
      cnt_new = cnt_q[upd_idx] + 2'd1;
    end else if (!upd_taken_i && (cnt_q[upd_idx] != 2'd0)) begin
      cnt_new = cnt_q[upd_idx] - 2'd1;
    end else begin
      cnt_new = cnt_q[upd_idx];
    end
  end

  // Valid bits
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (upd_valid_i) begin
      valid_q[upd_idx] <= 1'b1;
    end
  end

  // Tag, target and counter
  always_ff @(posedge clk_i) begin
    if (upd_valid_i) begin
      tag_q[upd_idx] <= upd_tag;
      cnt_q[upd_idx] <= cnt_new;
      // Keep the old target on a not-taken hit
      if (upd_taken_i || !upd_hit) begin
        target_q[upd_idx] <= upd_target_i;
      end
    end
  end

endmodule

/* verilog/fetch_ctrl.sv */
`timescale 1ns/1ps

module fetch_ctrl (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic pc_valid_i,
  input  logic redirect_i,
  input  logic buf_full_i,
  input  logic mem_ready_i,
  output logic mem_req_o,
  output logic req_accept_o,
  output logic pc_adv_o
);

  import fetch_pkg::*;

  fetch_state_t state_q;
  fetch_state_t state_d;

  // --------------------------------------------------------------------------
  // State machine
  // --------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      // One idle cycle out of reset
      FETCH_IDLE: begin
        state_d = FETCH_RUN;
      end
      FETCH_RUN: begin
        if (buf_full_i) begin
          state_d = FETCH_STALL;
        end
      end
      FETCH_STALL: begin
        // A redirect frees the buffer at the same edge
        if (!buf_full_i || redirect_i) begin
          state_d = FETCH_RUN;
        end
      end
      default: begin
        state_d = FETCH_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= FETCH_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // --------------------------------------------------------------------------
  // Request and PC advance
  // --------------------------------------------------------------------------

  // Gated by the next state so a full buffer blocks the request at once
  assign mem_req_o    = (state_q != FETCH_IDLE) & (state_d == FETCH_RUN) & pc_valid_i;
  assign req_accept_o = mem_req_o & mem_ready_i;
  // PC moves on an accepted request or any redirect
  assign pc_adv_o     = req_accept_o | redirect_i;

  a_no_req_when_full: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) mem_req_o |-> !buf_full_i
  );

endmodule

/* verilog/flush_drop_counter.sv */
`timescale 1ns/1ps

module flush_drop_counter (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic req_accept_i,
  input  logic rsp_valid_i,
  input  logic flush_i,
  output logic rsp_keep_o
);

  import fetch_pkg::*;

  // Requests in flight and wrong-path responses still owed
  logic [BUF_IDX_W:0] outst_q;
  logic [BUF_IDX_W:0] outst_d;
  logic [BUF_IDX_W:0] drop_q;

  // Nothing left to discard
  assign rsp_keep_o = (drop_q == '0);

  always_comb begin
    outst_d = outst_q;
    if (req_accept_i && !rsp_valid_i) begin
      outst_d = outst_q + 1'b1;
    end else if (!req_accept_i && rsp_valid_i) begin
      outst_d = outst_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      outst_q <= '0;
      drop_q  <= '0;
    end else begin
      outst_q <= outst_d;
      // Everything still in flight after a redirect is wrong path
      if (flush_i) begin
        drop_q <= outst_d;
      end else if (rsp_valid_i && !rsp_keep_o) begin
        drop_q <= drop_q - 1'b1;
      end
    end
  end

  // Memory answers only what was asked
  a_rsp_has_req: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) rsp_valid_i |-> outst_q != '0
  );

  // Credit limit held by fetch control
  a_outst_bound: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) outst_q <= (BUF_IDX_W+1)'(BUF_DEPTH)
  );

endmodule

/* verilog/instr_buffer.sv */
`timescale 1ns/1ps

module instr_buffer (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       alloc_i,
  input  logic [fetch_pkg::XLEN-1:0] alloc_pc_i,
  input  logic                       fill_i,
  input  logic [fetch_pkg::ILEN-1:0] fill_instr_i,
  input  logic                       flush_i,
  input  logic                       issue_ready_i,
  output logic                       full_o,
  output logic                       instr_valid_o,
  output logic [fetch_pkg::ILEN-1:0] instr_o,
  output logic [fetch_pkg::XLEN-1:0] instr_pc_o
);

  import fetch_pkg::*;

  // Entry payload
  logic [XLEN-1:0] pc_q    [BUF_DEPTH];
  logic [ILEN-1:0] instr_q [BUF_DEPTH];

  // Control
  logic [BUF_DEPTH-1:0] filled_q;
  logic [BUF_IDX_W-1:0] head_q;
  logic [BUF_IDX_W-1:0] fill_ptr_q;
  logic [BUF_IDX_W-1:0] tail_q;
  logic [BUF_IDX_W:0]   count_q;
  logic                 pop;

  // --------------------------------------------------------------------------
  // Decode side
  // --------------------------------------------------------------------------
  assign full_o        = (count_q == (BUF_IDX_W+1)'(BUF_DEPTH));
  // Head shown only once its response is in
  assign instr_valid_o = filled_q[head_q];
  assign instr_o       = instr_q[head_q];
  assign instr_pc_o    = pc_q[head_q];
  assign pop           = instr_valid_o & issue_ready_i;

  // --------------------------------------------------------------------------
  // Pointers and occupancy
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      head_q     <= '0;
      fill_ptr_q <= '0;
      tail_q     <= '0;
      count_q    <= '0;
      filled_q   <= '0;
    end else if (flush_i) begin
      // Drop every entry, pointers realigned
      head_q     <= '0;
      fill_ptr_q <= '0;
      tail_q     <= '0;
      count_q    <= '0;
      filled_q   <= '0;
    end else begin
      if (alloc_i) begin
        tail_q <= tail_q + 1'b1;
      end
      // Responses arrive in order
      if (fill_i) begin
        fill_ptr_q           <= fill_ptr_q + 1'b1;
        filled_q[fill_ptr_q] <= 1'b1;
      end
      if (pop) begin
        head_q           <= head_q + 1'b1;
        filled_q[head_q] <= 1'b0;
      end
      case ({alloc_i, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Payload writes
  always_ff @(posedge clk_i) begin
    if (alloc_i) begin
      pc_q[tail_q] <= alloc_pc_i;
    end
    if (fill_i) begin
      instr_q[fill_ptr_q] <= fill_instr_i;
    end
  end

  // Fill needs an allocated, still empty slot
  a_fill_target: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    fill_i |-> (fill_ptr_q != tail_q) || (full_o && !filled_q[fill_ptr_q])
  );

endmodule

/* verilog/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  // Commit
  input  logic                       comm_except_raised_i,
  input  logic [fetch_pkg::XLEN-1:0] comm_except_pc_i,
  // Branch unit
  input  logic                       bu_res_valid_i,
  input  logic [fetch_pkg::XLEN-1:0] bu_res_pc_i,
  input  logic [fetch_pkg::XLEN-1:0] bu_res_target_i,
  input  logic                       bu_res_taken_i,
  input  logic                       bu_res_mispredict_i,
  output logic                       bu_ready_o,
  // Instruction memory
  output logic                       mem_req_o,
  output logic [fetch_pkg::XLEN-1:0] mem_addr_o,
  input  logic                       mem_ready_i,
  input  logic                       mem_rsp_valid_i,
  input  logic [fetch_pkg::ILEN-1:0] mem_rsp_instr_i,
  // Decode
  output logic                       instr_valid_o,
  output logic [fetch_pkg::ILEN-1:0] instr_o,
  output logic [fetch_pkg::XLEN-1:0] instr_pc_o,
  input  logic                       issue_ready_i
);

  import fetch_pkg::*;

  logic [XLEN-1:0] pc;
  logic            pc_valid;
  logic            redirect;
  logic            pred_taken;
  logic [XLEN-1:0] pred_target;
  logic            pc_adv;
  logic            req_accept;
  logic            rsp_keep;
  logic            buf_full;
  logic            fetch_full;
  logic            buf_fill;

  assign mem_addr_o = pc;
  assign bu_ready_o = pc_adv;
  // Only kept responses reach the buffer
  assign buf_fill   = mem_rsp_valid_i & rsp_keep;
  // Hold requests while wrong-path responses drain
  assign fetch_full = buf_full | ~rsp_keep;

  pc_gen u_pc_gen (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .pc_adv_i(pc_adv),
    .comm_except_raised_i(comm_except_raised_i), .comm_except_pc_i(comm_except_pc_i),
    .bu_res_valid_i(bu_res_valid_i), .bu_res_mispredict_i(bu_res_mispredict_i),
    .bu_res_taken_i(bu_res_taken_i), .bu_res_pc_i(bu_res_pc_i),
    .bu_res_target_i(bu_res_target_i), .pred_taken_i(pred_taken),
    .pred_target_i(pred_target), .pc_o(pc), .pc_valid_o(pc_valid), .redirect_o(redirect)
  );

  // Trained by every resolution
  branch_predictor u_branch_predictor (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .lookup_pc_i(pc),
    .upd_valid_i(bu_res_valid_i), .upd_pc_i(bu_res_pc_i),
    .upd_target_i(bu_res_target_i), .upd_taken_i(bu_res_taken_i),
    .pred_taken_o(pred_taken), .pred_target_o(pred_target)
  );

  fetch_ctrl u_fetch_ctrl (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .pc_valid_i(pc_valid), .redirect_i(redirect),
    .buf_full_i(fetch_full), .mem_ready_i(mem_ready_i), .mem_req_o(mem_req_o),
    .req_accept_o(req_accept), .pc_adv_o(pc_adv)
  );

  flush_drop_counter u_flush_drop_counter (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .req_accept_i(req_accept),
    .rsp_valid_i(mem_rsp_valid_i), .flush_i(redirect), .rsp_keep_o(rsp_keep)
  );

  instr_buffer u_instr_buffer (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .alloc_i(req_accept), .alloc_pc_i(pc),
    .fill_i(buf_fill), .fill_instr_i(mem_rsp_instr_i), .flush_i(redirect),
    .issue_ready_i(issue_ready_i), .full_o(buf_full), .instr_valid_o(instr_valid_o),
    .instr_o(instr_o), .instr_pc_o(instr_pc_o)
  );

endmodule

/* verification/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 100 ns period
  localparam int HALF_PERIOD = 50;
  localparam int RESET_CYCLES = 2;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // Released on a rising edge, after the reset cycles
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

/* verification/tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       mem_req_i,
  input  logic [fetch_pkg::XLEN-1:0] mem_addr_i,
  output logic                       mem_ready_o = 1'b0,
  output logic                       mem_rsp_valid_o = 1'b0,
  output logic [fetch_pkg::ILEN-1:0] mem_rsp_instr_o = '0,
  output int                         pend_cnt_o = 0
);

  import fetch_pkg::*;

  localparam logic [ILEN-1:0] INSTR_KEY = 32'hA5A5A5A5;

  // Accepted requests, oldest first
  logic [XLEN-1:0] addr_q [$];
  int unsigned     due_q  [$];
  int unsigned     now;
  logic            rsp_now;

  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      addr_q.delete();
      due_q.delete();
      now = 0;
      mem_ready_o     <= 1'b0;
      mem_rsp_valid_o <= 1'b0;
      mem_rsp_instr_o <= '0;
      pend_cnt_o      <= 0;
    end else begin
      now = now + 1;
      // Head answers once its latency is up, younger ones wait behind it
      rsp_now = (due_q.size() > 0) && (due_q[0] <= now);
      if (rsp_now) begin
        mem_rsp_instr_o <= addr_q[0][ILEN-1:0] ^ INSTR_KEY;
        void'(addr_q.pop_front());
        void'(due_q.pop_front());
      end
      mem_rsp_valid_o <= rsp_now;
      if (mem_req_i && mem_ready_o) begin
        addr_q.push_back(mem_addr_i);
        due_q.push_back(now + $urandom_range(3, 1));
      end
      // Ready three cycles out of four
      mem_ready_o <= ($urandom % 4) != 0;
      // In flight as the DUT counts it, the response on the wire included
      pend_cnt_o  <= addr_q.size() + (rsp_now ? 1 : 0);
    end
  end

endmodule

/* verification/tb_fetch_unit.sv */
`timescale 1ns/1ps

module tb_fetch_unit;

  import fetch_pkg::*;

  localparam logic [ILEN-1:0] INSTR_KEY = 32'hA5A5A5A5;
  // Some 150 deliveries at up to a few cycles each, with wide margin
  localparam int TIMEOUT_CYCLES = 4000;

  logic            clk;
  logic            rst_n;
  logic            comm_except_raised;
  logic [XLEN-1:0] comm_except_pc;
  logic            bu_res_valid;
  logic [XLEN-1:0] bu_res_pc;
  logic [XLEN-1:0] bu_res_target;
  logic            bu_res_taken;
  logic            bu_res_mispredict;
  logic            bu_ready;
  logic            mem_req;
  logic [XLEN-1:0] mem_addr;
  logic            mem_ready;
  logic            mem_rsp_valid;
  logic [ILEN-1:0] mem_rsp_instr;
  int              mem_pend;
  logic            instr_valid;
  logic [ILEN-1:0] instr;
  logic [XLEN-1:0] instr_pc;
  logic            issue_ready = 1'b1;
  logic            bp_en;

  // Scoreboard state
  logic [XLEN-1:0] exp_pc;
  logic [XLEN-1:0] last_pc;
  logic [XLEN-1:0] pred_pc;
  logic [XLEN-1:0] pred_tgt;
  logic            pred_on;
  logic            deliver;
  logic            redirect_in;
  int              del_cnt;
  int              mismatch_cnt = 0;
  int              other_cnt = 0;
  int              cycle_cnt = 0;

  tb_clk_gen u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  tb_mem_model u_mem_model (
    .clk_i(clk), .rst_n_i(rst_n), .mem_req_i(mem_req), .mem_addr_i(mem_addr),
    .mem_ready_o(mem_ready), .mem_rsp_valid_o(mem_rsp_valid),
    .mem_rsp_instr_o(mem_rsp_instr), .pend_cnt_o(mem_pend)
  );

  fetch_unit dut_i (
    .clk_i(clk), .rst_n_i(rst_n),
    .comm_except_raised_i(comm_except_raised), .comm_except_pc_i(comm_except_pc),
    .bu_res_valid_i(bu_res_valid), .bu_res_pc_i(bu_res_pc),
    .bu_res_target_i(bu_res_target), .bu_res_taken_i(bu_res_taken),
    .bu_res_mispredict_i(bu_res_mispredict), .bu_ready_o(bu_ready),
    .mem_req_o(mem_req), .mem_addr_o(mem_addr), .mem_ready_i(mem_ready),
    .mem_rsp_valid_i(mem_rsp_valid), .mem_rsp_instr_i(mem_rsp_instr),
    .instr_valid_o(instr_valid), .instr_o(instr), .instr_pc_o(instr_pc),
    .issue_ready_i(issue_ready)
  );

  assign deliver     = instr_valid & issue_ready;
  assign redirect_in = comm_except_raised | (bu_res_valid & bu_res_mispredict);

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    // Decode stalls half the time when back-pressure is on
    issue_ready <= bp_en ? (($urandom % 2) == 1) : 1'b1;
  end

  // --------------------------------------------------------------------------
  // Expected decode stream
  // --------------------------------------------------------------------------
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_pc   <= BOOT_PC;
      last_pc  <= '0;
      pred_on  <= 1'b0;
      pred_pc  <= '0;
      pred_tgt <= '0;
      del_cnt  <= 0;
    end else begin
      if (deliver) begin
        last_pc <= instr_pc;
        del_cnt <= del_cnt + 1;
        // Trained taken branch goes straight to its target
        exp_pc  <= (pred_on && instr_pc == pred_pc) ? pred_tgt : instr_pc + 64'd4;
      end
      // Redirect wins over the delivery above, exception first
      if (comm_except_raised) begin
        exp_pc <= comm_except_pc;
      end else if (bu_res_valid && bu_res_mispredict) begin
        exp_pc <= bu_res_taken ? bu_res_target : bu_res_pc + 64'd4;
      end
      if (bu_res_valid && bu_res_taken) begin
        pred_on  <= 1'b1;
        pred_pc  <= bu_res_pc;
        pred_tgt <= bu_res_target;
      end
    end
  end

  a_pc_order: assert property (@(posedge clk) disable iff (!rst_n)
    deliver |-> instr_pc == exp_pc)
    else begin
      mismatch_cnt++;
      $display("mismatch instr_pc_o: got %h expected %h", $sampled(instr_pc), $sampled(exp_pc));
    end

  a_instr_data: assert property (@(posedge clk) disable iff (!rst_n)
    instr_valid |-> instr == (instr_pc[ILEN-1:0] ^ INSTR_KEY))
    else begin
      mismatch_cnt++;
      $display("mismatch instr_o: got %h expected %h", $sampled(instr),
               $sampled(instr_pc[ILEN-1:0]) ^ INSTR_KEY);
    end

  // PC advance strobe, one per accepted request or redirect
  a_bu_ready: assert property (@(posedge clk) disable iff (!rst_n)
    bu_ready == ((mem_req && mem_ready) || redirect_in))
    else begin
      mismatch_cnt++;
      $display("mismatch bu_ready_o: got %h expected %h", $sampled(bu_ready),
               $sampled((mem_req && mem_ready) || redirect_in));
    end

  // Held head stays put unless a redirect flushes it
  a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
    instr_valid && !issue_ready && !redirect_in |=>
    instr_valid && $stable(instr) && $stable(instr_pc))
    else begin
      other_cnt++;
      $display("decode output not held under back-pressure, pc now %h", $sampled(instr_pc));
    end

  a_mem_credit: assert property (@(posedge clk) disable iff (!rst_n) mem_pend <= BUF_DEPTH)
    else begin
      other_cnt++;
      $display("memory saw %0d requests outstanding, more than %0d", $sampled(mem_pend),
               BUF_DEPTH);
    end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  task automatic drive_redirect(input logic exc, input logic [XLEN-1:0] exc_pc,
                                input logic res, input logic [XLEN-1:0] res_pc,
                                input logic [XLEN-1:0] res_tgt, input logic taken,
                                input logic mispredict);
    @(posedge clk);
    comm_except_raised <= exc;
    comm_except_pc     <= exc_pc;
    bu_res_valid       <= res;
    bu_res_pc          <= res_pc;
    bu_res_target      <= res_tgt;
    bu_res_taken       <= taken;
    bu_res_mispredict  <= mispredict;
    @(posedge clk);
    comm_except_raised <= 1'b0;
    bu_res_valid       <= 1'b0;
  endtask

  task automatic wait_for_pc(input logic [XLEN-1:0] pc);
    while (last_pc != pc) begin
      @(posedge clk);
    end
  endtask

  task automatic finish_run(input bit timed_out);
    $display("errors: %0d mismatch, %0d other, %0d instructions delivered in %0d cycles",
             mismatch_cnt, other_cnt, del_cnt, cycle_cnt);
    if (timed_out || mismatch_cnt != 0 || other_cnt != 0) begin
      $display("test failed");
    end else begin
      $display("test passed");
    end
    $finish;
  endtask

  initial begin
    void'($urandom(32'hc489));
    comm_except_raised <= 1'b0;
    comm_except_pc     <= '0;
    bu_res_valid       <= 1'b0;
    bu_res_pc          <= '0;
    bu_res_target      <= '0;
    bu_res_taken       <= 1'b0;
    bu_res_mispredict  <= 1'b0;
    bp_en              <= 1'b0;
    wait (rst_n === 1'b1);
    // Straight-line fetch from boot
    wait_for_pc(BOOT_PC + 64'h2c);
    // Taken mispredict, then not-taken falling through
    drive_redirect(1'b0, '0, 1'b1, 64'h40_0010, 64'h2000, 1'b1, 1'b1);
    wait_for_pc(64'h2020);
    drive_redirect(1'b0, '0, 1'b1, 64'h3000, 64'hdead_0000, 1'b0, 1'b1);
    wait_for_pc(64'h3020);
    // Exception and mispredict together
    drive_redirect(1'b1, 64'h5000, 1'b1, 64'h40_0020, 64'h6000, 1'b1, 1'b1);
    wait_for_pc(64'h5020);
    // Train 8040 to 9000 twice, then fetch through it
    drive_redirect(1'b0, '0, 1'b1, 64'h8040, 64'h9000, 1'b1, 1'b1);
    wait_for_pc(64'h9010);
    drive_redirect(1'b0, '0, 1'b1, 64'h8040, 64'h9000, 1'b1, 1'b0);
    drive_redirect(1'b1, 64'h8030, 1'b0, '0, '0, 1'b0, 1'b0);
    wait_for_pc(64'h8040);
    wait_for_pc(64'h9010);
    // Random decode stalls, redirects landing on held instructions
    bp_en <= 1'b1;
    drive_redirect(1'b1, 64'hA000, 1'b0, '0, '0, 1'b0, 1'b0);
    wait_for_pc(64'hA040);
    drive_redirect(1'b0, '0, 1'b1, 64'h40_0030, 64'hB000, 1'b1, 1'b1);
    wait_for_pc(64'hB060);
    bp_en <= 1'b0;
    repeat (4) @(posedge clk);
    finish_run(1'b0);
  end

  initial begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    other_cnt++;
    $display("timeout after %0d cycles, last delivered pc %h", cycle_cnt, last_pc);
    finish_run(1'b1);
  end

endmodule

/* src.f */
verilog/fetch_pkg.sv
verilog/pc_gen.sv
verilog/branch_predictor.sv
verilog/fetch_ctrl.sv
verilog/flush_drop_counter.sv
verilog/instr_buffer.sv
verilog/fetch_unit.sv
verification/tb_clk_gen.sv
verification/tb_mem_model.sv
verification/tb_fetch_unit.sv
